//--- serial_pkg.sv
// --------------------
// serial link package
// word and counter types, controller states and fixed link settings
// --------------------

package serial_pkg;

	// --------------------
	// link settings
	// --------------------

	// bits per serial word
	localparam int word_bits = 8;

	// serial_clk cycles per half period of sclk
	localparam int clk_div = 4;

	// bit 0 goes on the line first
	localparam bit lsb_first = 1'b1;

	// line levels while nothing is sent
	localparam bit sclk_idle = 1'b1;
	localparam bit sdata_idle = 1'b1;

	// counter widths, at least one bit each
	localparam int bit_idx_bits = (word_bits > 1) ? $clog2(word_bits) : 1;
	localparam int div_cnt_bits = (clk_div > 1) ? $clog2(clk_div) : 1;

	// --------------------
	// types
	// --------------------

	// parallel data word
	typedef logic [word_bits-1:0] word_t;

	// position of a bit within a word
	typedef logic [bit_idx_bits-1:0] bit_idx_t;

	// divider count
	typedef logic [div_cnt_bits-1:0] div_cnt_t;

	// controller states
	typedef enum logic [0:0] {
		st_ready = 1'b0,
		st_transmit = 1'b1
	} ctrl_state_t;

endpackage

//--- sclk_gen.sv
// --------------------
// serial clock generator
// divides serial_clk into half-period ticks and forms the gated sclk line
// --------------------

`timescale 1ns/1ps

module sclk_gen (
	input logic serial_clk,
	input logic in_rst,
	input logic run,
	output logic sclk,
	output logic fall_tick,
	output logic rise_tick
);

	// --------------------
	// divider
	// --------------------

	serial_pkg::div_cnt_t div_cnt;

	// high when the next tick is a rise
	logic phase;

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			div_cnt <= '0;
			phase <= 1'b0;
			fall_tick <= 1'b0;
			rise_tick <= 1'b0;
		end else if (!run) begin
			// stopped, start over with a fall
			div_cnt <= '0;
			phase <= 1'b0;
			fall_tick <= 1'b0;
			rise_tick <= 1'b0;
		end else if (div_cnt == serial_pkg::div_cnt_t'(serial_pkg::clk_div - 1)) begin
			div_cnt <= '0;
			phase <= ~phase;
			// ticks alternate
			fall_tick <= ~phase;
			rise_tick <= phase;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			fall_tick <= 1'b0;
			rise_tick <= 1'b0;
		end
	end

	// --------------------
	// clock line
	// --------------------

	// follows the ticks one register later
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			sclk <= serial_pkg::sclk_idle;
		end else if (!run) begin
			sclk <= serial_pkg::sclk_idle;
		end else if (fall_tick) begin
			sclk <= 1'b0;
		end else if (rise_tick) begin
			sclk <= 1'b1;
		end
	end

	// both edges in one cycle would break the line protocol
	a_ticks_exclusive: assert property (@(posedge serial_clk) disable iff (in_rst)
		!(fall_tick && rise_tick));

endmodule

//--- serial_ctrl.sv
// --------------------
// serial link controller
// sequences words on the tick strobes and raises the word strobes
// --------------------

`timescale 1ns/1ps

module serial_ctrl (
	input logic serial_clk,
	input logic in_rst,
	input logic enable,
	input logic fall_tick,
	input logic rise_tick,
	output logic run,
	output logic load,
	output logic active,
	output logic ready,
	output logic transmitting,
	output logic next_word,
	output logic word_finished
);

	serial_pkg::ctrl_state_t state;
	serial_pkg::ctrl_state_t state_next;

	// bit currently on the line
	serial_pkg::bit_idx_t bit_cnt;
	serial_pkg::bit_idx_t bit_cnt_next;

	logic last_bit;
	logic second_last_bit;

	assign last_bit = (bit_cnt == serial_pkg::bit_idx_t'(serial_pkg::word_bits - 1));
	assign second_last_bit = (bit_cnt == serial_pkg::bit_idx_t'(serial_pkg::word_bits - 2));

	// --------------------
	// state register
	// --------------------

	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= serial_pkg::st_ready;
			bit_cnt <= '0;
		end else begin
			state <= state_next;
			bit_cnt <= bit_cnt_next;
		end
	end

	// --------------------
	// next state
	// --------------------

	// all decisions fall on a fall_tick
	always_comb begin
		state_next = state;
		bit_cnt_next = bit_cnt;
		load = 1'b0;
		next_word = 1'b0;

		if (fall_tick) begin
			if (!enable) begin
				// stop and drop any partial word
				state_next = serial_pkg::st_ready;
				bit_cnt_next = '0;
			end else if (state == serial_pkg::st_ready || last_bit) begin
				// new word starts with bit 0
				state_next = serial_pkg::st_transmit;
				bit_cnt_next = '0;
				load = 1'b1;
			end else begin
				bit_cnt_next = serial_pkg::bit_idx_t'(bit_cnt + 1'b1);
				// last bit starts here
				next_word = second_last_bit;
			end
		end
	end

	// --------------------
	// outputs
	// --------------------

	// sampled bit of the last position completes the word
	assign word_finished = rise_tick && (state == serial_pkg::st_transmit) && last_bit;

	// shifters act on the state that follows this cycle
	assign active = (state_next == serial_pkg::st_transmit);

	// keep the divider going while a word is open
	assign run = enable || (state == serial_pkg::st_transmit && !fall_tick);

	assign ready = (state == serial_pkg::st_ready);
	assign transmitting = (state == serial_pkg::st_transmit);

	// --------------------
	// checks
	// --------------------

	// last bit announced one half period before the word closes
	a_finish_in_transmit: assert property (@(posedge serial_clk) disable iff (in_rst)
		word_finished |-> state == serial_pkg::st_transmit
			&& $past(next_word, serial_pkg::clk_div));

	a_load_vs_next_word: assert property (@(posedge serial_clk) disable iff (in_rst)
		!(load && next_word));

endmodule

//--- tx_shifter.sv
// --------------------
// transmit shift register
// loads a parallel word and drives it bit by bit onto sdata_out
// --------------------

`timescale 1ns/1ps

module tx_shifter (
	input logic serial_clk,
	input logic in_rst,
	input serial_pkg::word_t parallel_in,
	input logic load,
	input logic fall_tick,
	input logic active,
	output logic sdata_out
);

	// bits still waiting for the line
	serial_pkg::word_t shift_q;

	// bit that goes out first
	function automatic logic first_bit(input serial_pkg::word_t w);
		if (serial_pkg::lsb_first) begin
			return w[0];
		end
		return w[serial_pkg::word_bits-1];
	endfunction

	// drop the bit just sent
	function automatic serial_pkg::word_t advance(input serial_pkg::word_t w);
		if (serial_pkg::lsb_first) begin
			return w >> 1;
		end
		return w << 1;
	endfunction

	// --------------------
	// shift register
	// --------------------

	always_ff @(posedge serial_clk) begin
		if (load) begin
			shift_q <= advance(parallel_in);
		end else if (fall_tick && active) begin
			shift_q <= advance(shift_q);
		end
	end

	// --------------------
	// data line
	// --------------------

	// changes together with the falling sclk edge
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			sdata_out <= serial_pkg::sdata_idle;
		end else if (!active) begin
			sdata_out <= serial_pkg::sdata_idle;
		end else if (load) begin
			sdata_out <= first_bit(parallel_in);
		end else if (fall_tick) begin
			sdata_out <= first_bit(shift_q);
		end
	end

	// line goes idle one register after the link stops
	a_idle_line: assert property (@(posedge serial_clk) disable iff (in_rst)
		!active |=> sdata_out == serial_pkg::sdata_idle);

endmodule

//--- rx_shifter.sv
// --------------------
// receive shift register
// samples sdata_in on rise ticks and holds each finished word
// --------------------

`timescale 1ns/1ps

module rx_shifter (
	input logic serial_clk,
	input logic in_rst,
	input logic sdata_in,
	input logic rise_tick,
	input logic active,
	input logic capture,
	output serial_pkg::word_t parallel_out
);

	// word under assembly
	serial_pkg::word_t assy_q;

	// assembly with the current line bit shifted in
	serial_pkg::word_t assy_next;

	// --------------------
	// bit ordering
	// --------------------

	always_comb begin
		if (serial_pkg::lsb_first) begin
			// first bit ends up in bit 0
			assy_next = {sdata_in, assy_q[serial_pkg::word_bits-1:1]};
		end else begin
			// first bit ends up in the top bit
			assy_next = {assy_q[serial_pkg::word_bits-2:0], sdata_in};
		end
	end

	// --------------------
	// assembly register
	// --------------------

	always_ff @(posedge serial_clk) begin
		if (rise_tick && active) begin
			assy_q <= assy_next;
		end
	end

	// --------------------
	// holding register
	// --------------------

	// takes the bit sampled at the capturing tick as well
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			parallel_out <= '0;
		end else if (capture) begin
			parallel_out <= assy_next;
		end
	end

	// capture must line up with a sampling tick of an open word
	a_capture_on_tick: assert property (@(posedge serial_clk) disable iff (in_rst)
		capture |-> rise_tick && active);

endmodule

//--- serial_master.sv
// --------------------
// 3-wire serial master
// controller with clock generator and transmit and receive shifters
// --------------------

`timescale 1ns/1ps

module serial_master (
	// main clock and reset
	input logic serial_clk,
	input logic in_rst,

	// parallel side
	input logic enable,
	input serial_pkg::word_t parallel_in,
	output serial_pkg::word_t parallel_out,
	output logic ready,
	output logic transmitting,
	output logic next_word,
	output logic word_finished,

	// serial lines
	output logic sclk,
	output logic sdata_out,
	input logic sdata_in
);

	// --------------------
	// internal strobes
	// --------------------

	// divider enable
	logic run;

	// half period ticks
	logic fall_tick;
	logic rise_tick;

	// shifter controls
	logic load;
	logic active;

	// --------------------
	// controller
	// --------------------

	serial_ctrl u_ctrl (
		.serial_clk (serial_clk),
		.in_rst (in_rst),
		.enable (enable),
		.fall_tick (fall_tick),
		.rise_tick (rise_tick),
		.run (run),
		.load (load),
		.active (active),
		.ready (ready),
		.transmitting (transmitting),
		.next_word (next_word),
		.word_finished (word_finished)
	);

	// --------------------
	// datapath
	// --------------------

	sclk_gen u_sclk_gen (
		.serial_clk (serial_clk),
		.in_rst (in_rst),
		.run (run),
		.sclk (sclk),
		.fall_tick (fall_tick),
		.rise_tick (rise_tick)
	);

	tx_shifter u_tx (
		.serial_clk (serial_clk),
		.in_rst (in_rst),
		.parallel_in (parallel_in),
		.load (load),
		.fall_tick (fall_tick),
		.active (active),
		.sdata_out (sdata_out)
	);

	// word_finished doubles as the capture strobe
	rx_shifter u_rx (
		.serial_clk (serial_clk),
		.in_rst (in_rst),
		.sdata_in (sdata_in),
		.rise_tick (rise_tick),
		.active (active),
		.capture (word_finished),
		.parallel_out (parallel_out)
	);

endmodule

//--- tb_serial_slave.sv
// --------------------
// far end model of the serial link
// receives words and answers with the inverse of the previous one
// --------------------

`timescale 1ns/1ps

module tb_serial_slave (
	input logic in_rst,
	input logic sclk,
	input logic sdata_out,
	output logic sdata_in,
	output serial_pkg::word_t rx_word,
	output int word_count
);

	// word being received
	serial_pkg::word_t rx_shift;

	// bits received of the current word
	int bit_cnt;

	// word going back to the master
	serial_pkg::word_t reply;

	// word bit that travels as line bit n
	function automatic int line_index(input int n);
		if (serial_pkg::lsb_first) begin
			return n;
		end
		return serial_pkg::word_bits - 1 - n;
	endfunction

	// --------------------
	// receive side
	// --------------------

	// master data is stable at the rising edge
	always @(posedge sclk or posedge in_rst) begin
		if (in_rst) begin
			rx_shift = '0;
			bit_cnt = 0;
			rx_word = '0;
			word_count = 0;
		end else begin
			rx_shift[line_index(bit_cnt)] = sdata_out;
			if (bit_cnt == serial_pkg::word_bits - 1) begin
				// word complete
				rx_word = rx_shift;
				word_count = word_count + 1;
				bit_cnt = 0;
			end else begin
				bit_cnt = bit_cnt + 1;
			end
		end
	end

	// --------------------
	// reply side
	// --------------------

	// new bit after each falling edge
	always @(negedge sclk or posedge in_rst) begin
		if (in_rst) begin
			reply = '0;
			sdata_in <= 1'b1;
		end else begin
			if (bit_cnt == 0) begin
				// word start, first word gets a fixed pattern
				if (word_count == 0) begin
					reply = 8'ha5;
				end else begin
					reply = ~rx_word;
				end
			end
			sdata_in <= reply[line_index(bit_cnt)];
		end
	end

endmodule

//--- tb_serial_master.sv
// --------------------
// testbench for the serial master
// streams words to the slave model and checks both directions
// --------------------

`timescale 1ns/1ps

module tb_serial_master;

	localparam int wait_limit = 2000;

	// cycles from one word_finished to the next in a stream
	localparam int word_cycles = 2 * serial_pkg::word_bits * serial_pkg::clk_div;

	// selectors for wait_for
	localparam int sel_next = 0;
	localparam int sel_finish = 1;
	localparam int sel_ready = 2;
	localparam int sel_busy = 3;

	logic serial_clk;
	logic in_rst;
	logic enable;
	serial_pkg::word_t parallel_in;
	serial_pkg::word_t parallel_out;
	logic ready;
	logic transmitting;
	logic next_word;
	logic word_finished;
	logic sclk;
	logic sdata_out;
	logic sdata_in;

	// slave side view
	serial_pkg::word_t slave_word;
	int slave_count;

	integer seed;
	int mismatches;
	int timeouts;

	// words on their way, oldest first
	serial_pkg::word_t sent_q[$];

	// compare process state
	serial_pkg::word_t exp_word;
	serial_pkg::word_t prev_sent;
	int words_done;
	int nw_count;
	logic cmp_pending;

	// stream timing and held output
	int cycle_cnt;
	int last_finish;
	serial_pkg::word_t held_out;

	// high while a stream must not pause
	logic gap_watch;

	serial_master uut (
		.serial_clk (serial_clk),
		.in_rst (in_rst),
		.enable (enable),
		.parallel_in (parallel_in),
		.parallel_out (parallel_out),
		.ready (ready),
		.transmitting (transmitting),
		.next_word (next_word),
		.word_finished (word_finished),
		.sclk (sclk),
		.sdata_out (sdata_out),
		.sdata_in (sdata_in)
	);

	tb_serial_slave u_slave (
		.in_rst (in_rst),
		.sclk (sclk),
		.sdata_out (sdata_out),
		.sdata_in (sdata_in),
		.rx_word (slave_word),
		.word_count (slave_count)
	);

	initial begin
		serial_clk = 1'b0;
	end

	always #5 serial_clk = ~serial_clk;

	// --------------------
	// helpers
	// --------------------

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
			mismatches++;
		end
	endtask

	// reply rule of the far end
	function automatic serial_pkg::word_t expected_reply(input serial_pkg::word_t prev,
		input bit first);
		if (first) begin
			return 8'ha5;
		end
		return ~prev;
	endfunction

	function automatic logic strobe_level(input int sel);
		case (sel)
			sel_next: return next_word;
			sel_finish: return word_finished;
			sel_ready: return ready;
			default: return transmitting;
		endcase
	endfunction

	// always moves on by at least one edge
	task automatic wait_for(input int sel, input string what);
		int n;
		n = 0;
		@(posedge serial_clk);
		while (strobe_level(sel) !== 1'b1 && n < wait_limit) begin
			@(posedge serial_clk);
			n++;
		end
		if (n >= wait_limit) begin
			$display("timeout while waiting for %s", what);
			timeouts++;
		end
	endtask

	// stop the link and see it return to idle
	task automatic stop_link();
		enable <= 1'b0;
		wait_for(sel_ready, "ready after stop");
		check("stop sclk", 1, sclk);
		check("stop sdata_out", 1, sdata_out);
	endtask

	task automatic send_single(input serial_pkg::word_t w);
		@(posedge serial_clk);
		parallel_in <= w;
		enable <= 1'b1;
		sent_q.push_back(w);
		wait_for(sel_finish, "word_finished");
		stop_link();
	endtask

	task automatic send_stream(input int count);
		serial_pkg::word_t w;
		int i;
		@(posedge serial_clk);
		w = serial_pkg::word_t'($random(seed));
		parallel_in <= w;
		enable <= 1'b1;
		sent_q.push_back(w);
		wait_for(sel_busy, "transmitting");
		gap_watch <= 1'b1;
		// next word goes in on each next_word
		for (i = 1; i < count; i++) begin
			wait_for(sel_next, "next_word");
			w = serial_pkg::word_t'($random(seed));
			parallel_in <= w;
			sent_q.push_back(w);
		end
		wait_for(sel_next, "next_word");
		wait_for(sel_finish, "word_finished");
		gap_watch <= 1'b0;
		stop_link();
	endtask

	// --------------------
	// compare process
	// --------------------

	// outputs are stable at the falling edge
	always @(negedge serial_clk) begin
		cycle_cnt++;
		if (cmp_pending) begin
			// parallel_out and the slave word settled one cycle after word_finished
			cmp_pending = 1'b0;
			if (sent_q.size() == 0) begin
				$display("word_finished came with no word sent");
				mismatches++;
			end else begin
				exp_word = sent_q.pop_front();
				check("slave word", exp_word, slave_word);
				check("slave count", words_done + 1, slave_count);
				check("reply", expected_reply(prev_sent, words_done == 0), parallel_out);
				prev_sent = exp_word;
				words_done++;
			end
			held_out = parallel_out;
		end else if (!in_rst) begin
			// parallel_out holds between captures
			check("parallel_out hold", held_out, parallel_out);
		end
		if (!in_rst) begin
			check("strobe overlap", 0, next_word & word_finished);
			if (gap_watch) begin
				check("stream gap", 1, transmitting);
			end
			if (next_word) begin
				check("one next_word per word", 0, nw_count);
				nw_count++;
			end
			if (word_finished) begin
				check("next_word before finish", 1, nw_count);
				// back to back words keep the full word period
				if (gap_watch && last_finish >= 0) begin
					check("word period", word_cycles, cycle_cnt - last_finish);
				end
				last_finish = gap_watch ? cycle_cnt : -1;
				nw_count = 0;
				cmp_pending = 1'b1;
			end
		end
	end

	// --------------------
	// stimulus
	// --------------------

	initial begin
		seed = 32'h47fd_0b8f;
		mismatches = 0;
		timeouts = 0;
		prev_sent = '0;
		words_done = 0;
		nw_count = 0;
		cmp_pending = 1'b0;
		cycle_cnt = 0;
		last_finish = -1;
		held_out = '0;
		gap_watch = 1'b0;
		in_rst <= 1'b1;
		enable <= 1'b0;
		parallel_in <= '0;
		repeat (4) @(posedge serial_clk);
		in_rst <= 1'b0;

		// reset and idle
		@(posedge serial_clk);
		check("reset ready", 1, ready);
		check("reset transmitting", 0, transmitting);
		check("reset sclk", 1, sclk);
		check("reset sdata_out", 1, sdata_out);
		check("reset parallel_out", 0, parallel_out);
		repeat (100) begin
			@(posedge serial_clk);
			check("idle sclk", 1, sclk);
		end

		// single word
		send_single(8'h3c);
		check("single slave word", 8'h3c, slave_word);
		check("single reply", 8'ha5, parallel_out);

		// back to back stream
		send_stream(20);

		// stays quiet after the stop and restarts
		repeat (50) begin
			@(posedge serial_clk);
			check("stopped sclk", 1, sclk);
			check("stopped sdata_out", 1, sdata_out);
		end
		send_single(serial_pkg::word_t'($random(seed)));
		repeat (4) @(posedge serial_clk);
		check("words left", 0, sent_q.size());

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
serial_pkg.sv
sclk_gen.sv
serial_ctrl.sv
tx_shifter.sv
rx_shifter.sv
serial_master.sv
tb_serial_slave.sv
tb_serial_master.sv
